/* files.f */
+incdir+.
fix_pkg.sv
fix_field_queue.sv
fix_msg_builder.sv
fix_checksum.sv
fix_byte_fifo.sv
fix_msg_tx.sv
fix_tb_clk.sv
fix_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the FIX serializer testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --top-module fix_tb -f files.f -o fix_sim \
	&& ./obj_dir/fix_sim > sim.log 2>&1 \
	|| echo "build or simulation did not complete"
[ -f sim.log ] && cat sim.log
grep -qx "sim passed" sim.log && exit 0 || exit 1

/* fix_tb.sv */
// FIX serializer testbench
`default_nettype none

`include "fix_defs.svh"

module fix_tb import fix_pkg::*; ();

	logic clk;
	logic rst;
	logic field_wr;
	fix_field_t field_data;
	logic field_full;
	logic byte_rd;
	fix_byte_t byte_data;
	logic byte_last;
	logic byte_empty;

	fix_field_t msg_q[$];
	logic [8:0] exp_q[$];
	integer seed = 32'h5106_9e9a;
	int read_mode;
	string test_name;

	fix_tb_clk fix_tb_clk_inst (
		.clk_o (clk),
		.rst_o (rst)
	);

	fix_msg_tx fix_msg_tx_inst (
		.clk (clk),
		.rst (rst),
		.field_wr_i (field_wr),
		.field_i (field_data),
		.field_full_o (field_full),
		.byte_rd_i (byte_rd),
		.byte_o (byte_data),
		.byte_last_o (byte_last),
		.byte_empty_o (byte_empty)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual)
			abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
	endtask

	// expected bytes of the message in msg_q, each with its last bit
	function automatic void fix_serialize();
		int sum;
		fix_byte_t b;
		sum = 0;
		foreach (msg_q[i]) begin
			for (int k = 0; k < int'(msg_q[i].tag_len); k++) begin
				b = msg_q[i].tag[8*k +: 8];
				exp_q.push_back({b, 1'b0});
				sum = sum + int'(b);
			end
			exp_q.push_back({8'h3d, 1'b0});
			sum = sum + 'h3d;
			for (int k = 0; k < int'(msg_q[i].val_len); k++) begin
				b = msg_q[i].value[8*k +: 8];
				exp_q.push_back({b, 1'b0});
				sum = sum + int'(b);
			end
			exp_q.push_back({8'h01, 1'b0});
			sum = sum + 1;
		end
		sum = sum % 256;
		exp_q.push_back({8'h31, 1'b0});
		exp_q.push_back({8'h30, 1'b0});
		exp_q.push_back({8'h3d, 1'b0});
		exp_q.push_back({8'(48 + sum / 100), 1'b0});
		exp_q.push_back({8'(48 + sum / 10 % 10), 1'b0});
		exp_q.push_back({8'(48 + sum % 10), 1'b0});
		exp_q.push_back({8'h01, 1'b1});
	endfunction

	function automatic fix_field_t make_field(input string t, input string v, input logic last);
		fix_field_t f;
		f = '0;
		f.tag_len = 3'(t.len());
		for (int k = 0; k < t.len(); k++)
			f.tag[8*k +: 8] = t[k];
		f.val_len = 4'(v.len());
		for (int k = 0; k < v.len(); k++)
			f.value[8*k +: 8] = v[k];
		f.last = last;
		return f;
	endfunction

	// numeric tag, printable value
	function automatic fix_field_t random_field(input logic last);
		fix_field_t f;
		int unsigned r;
		f = '0;
		r = $random(seed);
		f.tag_len = 3'(1 + r % `FIX_TAG_BYTES);
		r = $random(seed);
		f.val_len = 4'(1 + r % `FIX_VAL_BYTES);
		for (int k = 0; k < int'(f.tag_len); k++) begin
			r = $random(seed);
			f.tag[8*k +: 8] = 8'(48 + r % 10);
		end
		for (int k = 0; k < int'(f.val_len); k++) begin
			r = $random(seed);
			f.value[8*k +: 8] = 8'(33 + r % 94);
		end
		f.last = last;
		return f;
	endfunction

	task automatic write_field(input fix_field_t f);
		int n;
		n = 0;
		@(negedge clk);
		while (field_full) begin
			if (n >= 1000)
				abort_run({"field queue stayed full in ", test_name});
			n++;
			@(negedge clk);
		end
		@(posedge clk);
		field_wr <= 1'b1;
		field_data <= f;
		@(posedge clk);
		field_wr <= 1'b0;
	endtask

	// expected bytes go in first, the reader may overtake the writer
	task automatic send_msg();
		fix_serialize();
		foreach (msg_q[i])
			write_field(msg_q[i]);
		msg_q.delete();
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		@(negedge clk);
		while (rst) begin
			if (n >= 20)
				abort_run("reset was never released");
			n++;
			@(negedge clk);
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0) begin
			if (n >= 10000)
				abort_run($sformatf("output stalled in %s with %0d bytes unread",
					test_name, exp_q.size()));
			n++;
			@(negedge clk);
		end
		@(posedge clk);
		@(negedge clk);
		check_value({test_name, " drained"}, 32'(1), 32'(byte_empty));
	endtask

	task automatic fill_until_full();
		int n;
		n = 0;
		forever begin
			@(negedge clk);
			if (field_full)
				break;
			if (n >= 32)
				abort_run("field_full_o never rose with reading stopped");
			msg_q.push_back(random_field(1'b1));
			send_msg();
			n++;
		end
	endtask

	// 0 stopped, 1 every cycle, 2 random gaps
	always @(posedge clk) begin
		int unsigned r;
		if (rst)
			byte_rd <= 1'b0;
		else if (read_mode == 0)
			byte_rd <= 1'b0;
		else if (read_mode == 1)
			byte_rd <= 1'b1;
		else begin
			r = $random(seed);
			byte_rd <= (r[1:0] != 2'b00);
		end
	end

	// a read takes effect at the next rising edge
	always @(negedge clk) begin
		if (!rst && byte_rd && !byte_empty) begin
			if (exp_q.size() == 0)
				abort_run({"byte read with nothing expected in ", test_name});
			else
				check_value(test_name, 32'(exp_q.pop_front()), 32'({byte_data, byte_last}));
		end
	end

	initial begin
		int unsigned r;
		int nf;
		field_wr = 1'b0;
		field_data = '0;
		byte_rd = 1'b0;
		read_mode = 0;
		test_name = "reset";
		wait_reset();
		@(negedge clk);
		check_value("reset empty", 32'(1), 32'(byte_empty));
		check_value("reset full", 32'(0), 32'(field_full));

		test_name = "single field";
		read_mode = 1;
		msg_q.push_back(make_field("35", "D", 1'b1));
		send_msg();
		wait_drain();

		test_name = "length limits";
		msg_q.push_back(make_field("8", "X", 1'b0));
		msg_q.push_back(make_field("9999", "ABCDEFGH", 1'b0));
		msg_q.push_back(make_field("1234", "Z", 1'b0));
		msg_q.push_back(make_field("7", "12345678", 1'b1));
		send_msg();
		msg_q.push_back(make_field("55", "IBM", 1'b1));
		send_msg();
		wait_drain();

		// body sums of 261 and 298, digits 005 and 042
		test_name = "leading zeros";
		msg_q.push_back(make_field("1", "KK", 1'b1));
		send_msg();
		msg_q.push_back(make_field("1", "Za", 1'b1));
		send_msg();
		wait_drain();

		test_name = "back-pressure";
		read_mode = 0;
		fill_until_full();
		read_mode = 1;
		wait_drain();

		test_name = "random";
		read_mode = 2;
		for (int m = 0; m < 40; m++) begin
			@(negedge clk);
			r = $random(seed);
			nf = 1 + r % 3;
			for (int i = 0; i < nf; i++)
				msg_q.push_back(random_field(i == nf - 1));
			send_msg();
		end
		wait_drain();

		if (exp_q.size() != 0 || !byte_empty) begin
			$display("output stream ended with bytes missing or left over");
			$display("sim failed");
			$fatal(1);
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* fix_tb_clk.sv */
// FIX testbench clock and reset
`default_nettype none

module fix_tb_clk (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o;
	end

	// held for four rising edges
	initial begin
		rst_o = 1'b1;
		repeat (4) @(posedge clk_o);
		rst_o <= 1'b0;
	end

endmodule

`default_nettype wire

/* fix_msg_tx.sv */
// FIX message transmitter top
`default_nettype none

module fix_msg_tx import fix_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic field_wr_i,
	input wire fix_field_t field_i,
	output logic field_full_o,
	input wire logic byte_rd_i,
	output fix_byte_t byte_o,
	output logic byte_last_o,
	output logic byte_empty_o
);

	fix_field_t head;
	logic field_empty;
	logic pop;
	fix_out_t out;
	logic push;
	logic out_full;
	logic trailer;
	fix_digits_t digits;
	fix_out_t fifo_head;

	fix_field_queue fix_field_queue_inst (
		.clk (clk),
		.rst (rst),
		.wr_i (field_wr_i),
		.field_i (field_i),
		.full_o (field_full_o),
		.pop_i (pop),
		.head_o (head),
		.empty_o (field_empty)
	);

	fix_msg_builder fix_msg_builder_inst (
		.clk (clk),
		.rst (rst),
		.field_i (head),
		.field_empty_i (field_empty),
		.pop_o (pop),
		.out_o (out),
		.push_o (push),
		.out_full_i (out_full),
		.trailer_o (trailer),
		.digits_i (digits)
	);

	// sees every pushed byte
	fix_checksum fix_checksum_inst (
		.clk (clk),
		.rst (rst),
		.byte_i (out.data),
		.push_i (push),
		.last_i (out.last),
		.trailer_i (trailer),
		.digits_o (digits)
	);

	fix_byte_fifo fix_byte_fifo_inst (
		.clk (clk),
		.rst (rst),
		.push_i (push),
		.data_i (out),
		.full_o (out_full),
		.rd_i (byte_rd_i),
		.head_o (fifo_head),
		.empty_o (byte_empty_o)
	);

	assign byte_o = fifo_head.data;
	assign byte_last_o = fifo_head.last;

endmodule

`default_nettype wire

/* fix_byte_fifo.sv */
// FIX output byte FIFO
`default_nettype none

`include "fix_defs.svh"

module fix_byte_fifo import fix_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic push_i,
	input wire fix_out_t data_i,
	output logic full_o,
	input wire logic rd_i,
	output fix_out_t head_o,
	output logic empty_o
);

	localparam int PW = $clog2(`FIX_BYTE_DEPTH);
	localparam int CW = $clog2(`FIX_BYTE_DEPTH + 1);
	localparam logic [CW-1:0] DEPTH_C = CW'(`FIX_BYTE_DEPTH);

	fix_out_t mem [`FIX_BYTE_DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic do_push;
	logic do_rd;

	assign do_push = push_i && !full_o;
	// read on empty is dropped
	assign do_rd = rd_i && !empty_o;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= data_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + CW'(do_push) - CW'(do_rd);
		end
	end

	// head shown ahead of the read
	assign head_o = mem[rd_ptr];
	assign full_o = (count == DEPTH_C);
	assign empty_o = (count == '0);

	a_no_push_full: assert property (@(posedge clk) disable iff (rst) !(push_i && full_o))
		else $error("byte fifo pushed while full");

	// a byte that is pushed into an empty fifo is at the head next cycle
	a_fwft: assert property (@(posedge clk) disable iff (rst)
		(do_push && empty_o && !rd_i) |=> (!empty_o && head_o == $past(data_i)))
		else $error("pushed byte not at fifo head");

endmodule

`default_nettype wire

/* fix_checksum.sv */
// FIX body checksum
`default_nettype none

`include "fix_defs.svh"

module fix_checksum import fix_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire fix_byte_t byte_i,
	input wire logic push_i,
	input wire logic last_i,
	input wire logic trailer_i,
	output fix_digits_t digits_o
);

	fix_byte_t sum;

	// sum is frozen through the trailer, cleared on the final byte
	always_ff @(posedge clk) begin
		if (rst)
			sum <= '0;
		else if (push_i) begin
			if (last_i)
				sum <= '0;
			else if (!trailer_i)
				sum <= sum + byte_i;
		end
	end

	always_comb begin
		fix_byte_t rem;
		logic [3:0] hund;
		logic [3:0] tens;
		rem = sum;
		hund = 4'd0;
		tens = 4'd0;
		if (rem >= 8'd200) begin
			rem = rem - 8'd200;
			hund = 4'd2;
		end else if (rem >= 8'd100) begin
			rem = rem - 8'd100;
			hund = 4'd1;
		end
		// at most nine tens left
		for (int k = 0; k < 9; k++) begin
			if (rem >= 8'd10) begin
				rem = rem - 8'd10;
				tens = tens + 4'd1;
			end
		end
		digits_o.hundreds = `FIX_ASCII_ZERO + {4'd0, hund};
		digits_o.tens = `FIX_ASCII_ZERO + {4'd0, tens};
		digits_o.ones = `FIX_ASCII_ZERO + rem;
	end

endmodule

`default_nettype wire

/* fix_msg_builder.sv */
// FIX message byte sequencer
`default_nettype none

`include "fix_defs.svh"

module fix_msg_builder import fix_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire fix_field_t field_i,
	input wire logic field_empty_i,
	output logic pop_o,
	output fix_out_t out_o,
	output logic push_o,
	input wire logic out_full_i,
	output logic trailer_o,
	input wire fix_digits_t digits_i
);

	localparam int IW = $clog2(`FIX_VAL_BYTES);
	localparam int TW = $clog2(`FIX_TAG_BYTES);

	fix_state_e state;
	fix_state_e state_d;
	fix_field_t fld;
	logic [IW-1:0] idx;
	logic [TW-1:0] tag_idx;
	logic tag_done;
	logic val_done;
	logic step;

	assign tag_idx = idx[TW-1:0];
	assign tag_done = (idx == IW'(fld.tag_len - 3'd1));
	assign val_done = ({1'b0, idx} == (fld.val_len - 4'd1));

	// every state but IDLE emits one byte
	assign push_o = (state != IDLE) && !out_full_i;
	assign pop_o = (state == SOH) && !out_full_i;
	assign trailer_o = (state >= CK_ONE);

	// index walks within the tag or value, else restarts
	assign step = (state == TAG && !tag_done) || (state == VAL && !val_done);

	always_comb begin
		state_d = state;
		case (state)
			IDLE: begin
				if (!field_empty_i)
					state_d = TAG;
			end
			TAG: begin
				if (tag_done)
					state_d = EQ;
			end
			EQ: state_d = VAL;
			VAL: begin
				if (val_done)
					state_d = SOH;
			end
			SOH: state_d = fld.last ? CK_ONE : IDLE;
			CK_ONE: state_d = CK_ZERO;
			CK_ZERO: state_d = CK_EQ;
			CK_EQ: state_d = CK_D2;
			CK_D2: state_d = CK_D1;
			CK_D1: state_d = CK_D0;
			CK_D0: state_d = CK_SOH;
			CK_SOH: state_d = IDLE;
			default: state_d = IDLE;
		endcase
		// stall while the byte fifo is full
		if (state != IDLE && out_full_i)
			state_d = state;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			idx <= '0;
		end else begin
			state <= state_d;
			if (push_o)
				idx <= step ? idx + 1'b1 : '0;
		end
	end

	// head is held by the queue until the pop
	always_ff @(posedge clk) begin
		if (state == IDLE && !field_empty_i)
			fld <= field_i;
	end

	always_comb begin
		out_o.last = (state == CK_SOH);
		case (state)
			TAG: out_o.data = fld.tag[{tag_idx, 3'b000} +: 8];
			EQ: out_o.data = `FIX_ASCII_EQ;
			VAL: out_o.data = fld.value[{idx, 3'b000} +: 8];
			CK_ONE: out_o.data = `FIX_ASCII_ONE;
			CK_ZERO: out_o.data = `FIX_ASCII_ZERO;
			CK_EQ: out_o.data = `FIX_ASCII_EQ;
			CK_D2: out_o.data = digits_i.hundreds;
			CK_D1: out_o.data = digits_i.tens;
			CK_D0: out_o.data = digits_i.ones;
			default: out_o.data = `FIX_ASCII_SOH;
		endcase
	end

	a_field_len: assert property (@(posedge clk) disable iff (rst)
		(state == TAG) |-> (fld.tag_len != '0 && fld.val_len != '0))
		else $error("latched field with zero length");

	a_no_push_full: assert property (@(posedge clk) disable iff (rst)
		!(push_o && out_full_i))
		else $error("builder pushed into full byte fifo");

endmodule

`default_nettype wire

/* fix_field_queue.sv */
// FIX field queue
`default_nettype none

`include "fix_defs.svh"

module fix_field_queue import fix_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic wr_i,
	input wire fix_field_t field_i,
	output logic full_o,
	input wire logic pop_i,
	output fix_field_t head_o,
	output logic empty_o
);

	localparam int PW = $clog2(`FIX_FIELD_DEPTH);
	localparam int CW = $clog2(`FIX_FIELD_DEPTH + 1);
	localparam logic [CW-1:0] DEPTH_C = CW'(`FIX_FIELD_DEPTH);

	fix_field_t mem [`FIX_FIELD_DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic do_wr;
	logic do_pop;

	assign do_wr = wr_i && !full_o;
	assign do_pop = pop_i && !empty_o;

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= field_i;
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + CW'(do_wr) - CW'(do_pop);
		end
	end

	assign head_o = mem[rd_ptr];
	assign full_o = (count == DEPTH_C);
	assign empty_o = (count == '0);

	a_no_wr_full: assert property (@(posedge clk) disable iff (rst) !(wr_i && full_o))
		else $error("field queue written while full");
	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) !(pop_i && empty_o))
		else $error("field queue popped while empty");

endmodule

`default_nettype wire

/* fix_pkg.sv */
// FIX serializer types
`default_nettype none

`include "fix_defs.svh"

package fix_pkg;

	typedef logic [7:0] fix_byte_t;
	typedef logic [`FIX_TAG_BYTES*8-1:0] fix_tag_t;
	typedef logic [`FIX_VAL_BYTES*8-1:0] fix_val_t;

	// one host field, first byte in the low bits
	typedef struct packed {
		fix_tag_t tag;
		logic [2:0] tag_len;
		fix_val_t value;
		logic [3:0] val_len;
		logic last;
	} fix_field_t;

	typedef struct packed {
		fix_byte_t data;
		logic last;
	} fix_out_t;

	// checksum as three ascii digits
	typedef struct packed {
		fix_byte_t hundreds;
		fix_byte_t tens;
		fix_byte_t ones;
	} fix_digits_t;

	typedef enum logic [3:0] {
		IDLE, TAG, EQ, VAL, SOH,
		CK_ONE, CK_ZERO, CK_EQ, CK_D2, CK_D1, CK_D0, CK_SOH
	} fix_state_e;

endpackage

`default_nettype wire

/* fix_defs.svh */
// FIX serializer parameters
`ifndef FIX_DEFS_SVH
`define FIX_DEFS_SVH

// field sizes in bytes
`define FIX_TAG_BYTES 4
`define FIX_VAL_BYTES 8

// storage depths, powers of two
`define FIX_FIELD_DEPTH 4
`define FIX_BYTE_DEPTH 16

// ascii characters used by the framing
`define FIX_ASCII_SOH 8'h01
`define FIX_ASCII_EQ 8'h3d
`define FIX_ASCII_ZERO 8'h30
`define FIX_ASCII_ONE 8'h31

`endif
